//--- hdl/OramCryptPkg.sv
// ----------------------------------------------------------
// Shared widths, enums and the keystream round function of
// the bucket encryption layer. Imported by every RTL block.
// ----------------------------------------------------------
`default_nettype none

package OramCryptPkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------

    // One DRAM beat
    localparam int DataWidth = 64;

    // IV field in the low bits of a bucket header beat
    localparam int IvWidth = 16;

    // Rounds of the keystream, one per pipeline stage
    localparam int KeystreamRounds = 3;

    // Added once per round, scaled by the round number plus one
    localparam logic [DataWidth-1:0] GoldenStep = 64'h9E3779B97F4A7C15;

    // ----------------------------------------------------------
    // Enums
    // ----------------------------------------------------------

    // Direction tag carried by every beat
    typedef enum logic {
        DirRead,
        DirWrite
    } PathDir;

    // Path alternation, with a drain between directions
    typedef enum logic [1:0] {
        ReadPath,
        DrainToWrite,
        WritePath,
        DrainToRead
    } PathState;

    // ----------------------------------------------------------
    // Keystream round
    // ----------------------------------------------------------

    // Rotate left by 13 plus round, mix in the key, add the step.
    // A keystream word is rounds 0, 1, 2 applied to the counter.
    function automatic logic [DataWidth-1:0] mixRound(
        input logic [DataWidth-1:0] state,
        input logic [DataWidth-1:0] key,
        input int unsigned round
    );
        int unsigned rot;
        logic [DataWidth-1:0] rotated;
        logic [DataWidth-1:0] step;
        rot = (13 + round) % DataWidth;
        rotated = (state << rot) | (state >> (DataWidth - rot));
        // Product truncated to 64 bits
        step = GoldenStep * DataWidth'(round + 1);
        return (rotated ^ key) + step;
    endfunction

endpackage

`default_nettype wire

//--- hdl/BeatStream.sv
// ----------------------------------------------------------
// One pipeline beat with keystream, IV and tags, moved by
// valid/ready from the keystream pipe to the merge stage.
// ----------------------------------------------------------
`default_nettype none

interface BeatStream import OramCryptPkg::*; ();

    logic [DataWidth-1:0] Data;
    logic [DataWidth-1:0] Keystream;
    logic [IvWidth-1:0]   Iv;
    logic                 Header;
    PathDir               Dir;
    logic                 Valid;
    logic                 Ready;

    // Producer side
    modport Source (
        output Data, Keystream, Iv, Header, Dir, Valid,
        input  Ready
    );

    // Consumer side
    modport Sink (
        input  Data, Keystream, Iv, Header, Dir, Valid,
        output Ready
    );

endinterface

`default_nettype wire

//--- hdl/PathDirectionFsm.sv
// ----------------------------------------------------------
// Alternates read and write paths, starting with read, and
// holds input off while the pipeline drains between them.
// ----------------------------------------------------------
`default_nettype none

module PathDirectionFsm import OramCryptPkg::*; (
    input  wire    Clock,
    input  wire    rstN,
    input  wire    PathDone,
    input  wire    PipeEmpty,
    output PathDir Mode,
    output logic   InputHold
);

    PathState state;
    PathState nextState;

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            ReadPath: begin
                if (PathDone) begin
                    nextState = DrainToWrite;
                end
            end
            DrainToWrite: begin
                if (PipeEmpty) begin
                    nextState = WritePath;
                end
            end
            WritePath: begin
                if (PathDone) begin
                    nextState = DrainToRead;
                end
            end
            default: begin
                if (PipeEmpty) begin
                    nextState = ReadPath;
                end
            end
        endcase
    end

    // Hold is registered so both input readies stay low in reset
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= ReadPath;
            InputHold <= 1'b1;
        end else begin
            state <= nextState;
            InputHold <= (nextState == DrainToWrite) || (nextState == DrainToRead);
        end
    end

    // Drain keeps the old direction until the switch
    assign Mode = ((state == WritePath) || (state == DrainToRead)) ? DirWrite : DirRead;

endmodule

`default_nettype wire

//--- hdl/BucketBeatCounter.sv
// ----------------------------------------------------------
// Counts accepted input beats by bucket and by path. Gives
// the beat position, the header flag and the end of a path.
// ----------------------------------------------------------
`default_nettype none

module BucketBeatCounter import OramCryptPkg::*; #(
    parameter int BucketBeats = 4,
    parameter int PathBuckets = 3
) (
    input  wire                Clock,
    input  wire                rstN,
    input  wire                InFire,
    output logic [IvWidth-1:0] BeatIndex,
    output logic               Header,
    output logic               PathDone
);

    logic [IvWidth-1:0] beatCount;
    logic [IvWidth-1:0] bucketCount;
    logic               lastBeat;
    logic               lastBucket;

    assign lastBeat = (beatCount == IvWidth'(BucketBeats - 1));
    assign lastBucket = (bucketCount == IvWidth'(PathBuckets - 1));

    // Both counts wrap to zero after the final beat of a path
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            beatCount <= '0;
            bucketCount <= '0;
        end else if (InFire) begin
            if (lastBeat) begin
                beatCount <= '0;
                bucketCount <= lastBucket ? '0 : bucketCount + 1'b1;
            end else begin
                beatCount <= beatCount + 1'b1;
            end
        end
    end

    assign BeatIndex = beatCount;
    assign Header = (beatCount == '0);

    // High only during the accept of the last beat
    assign PathDone = InFire && lastBeat && lastBucket;

endmodule

`default_nettype wire

//--- hdl/KeystreamPipe.sv
// ----------------------------------------------------------
// Picks the input side by direction, keeps the bucket IV and
// runs the keystream rounds in a stalling three-stage pipe.
// ----------------------------------------------------------
`default_nettype none

module KeystreamPipe import OramCryptPkg::*; #(
    parameter logic [DataWidth-1:0] CryptKey = 64'h0123456789ABCDEF
) (
    input  wire                  Clock,
    input  wire                  rstN,
    input  PathDir               Mode,
    input  wire                  InputHold,
    input  wire  [DataWidth-1:0] MemInData,
    input  wire                  MemInValid,
    output logic                 MemInReady,
    input  wire  [DataWidth-1:0] BackendWData,
    input  wire                  BackendWValid,
    output logic                 BackendWReady,
    input  wire  [IvWidth-1:0]   BeatIndex,
    input  wire                  Header,
    output logic                 InFire,
    output logic                 PipeEmpty,
    BeatStream.Source            Out
);

    localparam int Last = KeystreamRounds - 1;

    logic                 advance;
    logic                 acceptOpen;
    logic [DataWidth-1:0] inData;
    logic                 inValid;
    logic [IvWidth-1:0]   ivReg;
    logic [IvWidth-1:0]   curIv;
    logic [DataWidth-1:0] counter;

    logic [KeystreamRounds-1:0] validStage;
    logic [DataWidth-1:0]       dataStage [KeystreamRounds];
    logic [DataWidth-1:0]       ksStage [KeystreamRounds];
    logic [IvWidth-1:0]         ivStage [KeystreamRounds];
    logic                       headerStage [KeystreamRounds];
    PathDir                     dirStage [KeystreamRounds];

    // ----------------------------------------------------------
    // Input steering
    // ----------------------------------------------------------

    // Whole pipe moves when the last stage is empty or taken
    assign advance = !validStage[Last] || Out.Ready;
    assign acceptOpen = advance && !InputHold;

    assign MemInReady = acceptOpen && (Mode == DirRead);
    assign BackendWReady = acceptOpen && (Mode == DirWrite);

    assign inData = (Mode == DirRead) ? MemInData : BackendWData;
    assign inValid = (Mode == DirRead) ? MemInValid : BackendWValid;
    assign InFire = acceptOpen && inValid;

    // Header beat carries its own IV, later beats use the held one
    assign curIv = Header ? inData[IvWidth-1:0] : ivReg;
    assign counter = DataWidth'(curIv) + DataWidth'(BeatIndex);

    always_ff @(posedge Clock) begin
        if (InFire && Header) begin
            ivReg <= inData[IvWidth-1:0];
        end
    end

    // ----------------------------------------------------------
    // Round stages
    // ----------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            validStage <= '0;
        end else if (advance) begin
            validStage <= {validStage[Last-1:0], InFire};
        end
    end

    always_ff @(posedge Clock) begin
        if (advance) begin
            dataStage[0] <= inData;
            ksStage[0] <= mixRound(counter, CryptKey, 0);
            ivStage[0] <= curIv;
            headerStage[0] <= Header;
            dirStage[0] <= Mode;
            for (int s = 1; s < KeystreamRounds; s++) begin
                dataStage[s] <= dataStage[s-1];
                ksStage[s] <= mixRound(ksStage[s-1], CryptKey, s);
                ivStage[s] <= ivStage[s-1];
                headerStage[s] <= headerStage[s-1];
                dirStage[s] <= dirStage[s-1];
            end
        end
    end

    assign PipeEmpty = !(|validStage);

    assign Out.Data = dataStage[Last];
    assign Out.Keystream = ksStage[Last];
    assign Out.Iv = ivStage[Last];
    assign Out.Header = headerStage[Last];
    assign Out.Dir = dirStage[Last];
    assign Out.Valid = validStage[Last];

endmodule

`default_nettype wire

//--- hdl/CipherMerge.sv
// ----------------------------------------------------------
// XORs each beat with its keystream word, puts the clear IV
// back into headers and registers the result per direction.
// ----------------------------------------------------------
`default_nettype none

module CipherMerge import OramCryptPkg::*; (
    input  wire                  Clock,
    input  wire                  rstN,
    BeatStream.Sink              In,
    input  wire                  MemOutReady,
    output logic [DataWidth-1:0] BackendRData,
    output logic                 BackendRValid,
    output logic [DataWidth-1:0] MemOutData,
    output logic                 MemOutValid
);

    logic [DataWidth-1:0] xorRes;
    logic [DataWidth-1:0] merged;
    logic                 readFire;
    logic                 writeFire;
    logic                 memLoad;

    // ----------------------------------------------------------
    // Cipher
    // ----------------------------------------------------------
    assign xorRes = In.Data ^ In.Keystream;

    always_comb begin
        merged = xorRes;
        if (In.Header) begin
            merged[IvWidth-1:0] = In.Iv;
        end
    end

    // Write beats wait on memory. Read beats only wait for a
    // leftover write beat so the two outputs never overlap.
    assign In.Ready = (In.Dir == DirWrite) ? MemOutReady : !MemOutValid;

    assign readFire = In.Valid && In.Ready && (In.Dir == DirRead);
    assign writeFire = In.Valid && In.Ready && (In.Dir == DirWrite);

    // Memory register reloads when empty or taken
    assign memLoad = MemOutReady || !MemOutValid;

    // ----------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            BackendRValid <= 1'b0;
            MemOutValid <= 1'b0;
        end else begin
            // Backend has no ready, one-cycle pulse per beat
            BackendRValid <= readFire;
            if (memLoad) begin
                MemOutValid <= writeFire;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (readFire) begin
            BackendRData <= merged;
        end
        if (memLoad) begin
            MemOutData <= merged;
        end
    end

endmodule

`default_nettype wire

//--- hdl/OramCryptTop.sv
// ----------------------------------------------------------
// Bucket encryption layer between path backend and DRAM.
// Alternates read (decrypt) and write (encrypt) paths.
// ----------------------------------------------------------
`default_nettype none

module OramCryptTop import OramCryptPkg::*; #(
    parameter int                   BucketBeats = 4,
    parameter int                   PathBuckets = 3,
    parameter logic [DataWidth-1:0] CryptKey = 64'h0123456789ABCDEF
) (
    input  wire                  Clock,
    input  wire                  rstN,

    // Memory to layer
    input  wire  [DataWidth-1:0] MemInData,
    input  wire                  MemInValid,
    output logic                 MemInReady,

    // Backend to layer
    input  wire  [DataWidth-1:0] BackendWData,
    input  wire                  BackendWValid,
    output logic                 BackendWReady,

    // Layer to backend, no ready
    output logic [DataWidth-1:0] BackendRData,
    output logic                 BackendRValid,

    // Layer to memory
    output logic [DataWidth-1:0] MemOutData,
    output logic                 MemOutValid,
    input  wire                  MemOutReady
);

    PathDir             mode;
    logic               inputHold;
    logic               pathDone;
    logic               pipeEmpty;
    logic               inFire;
    logic [IvWidth-1:0] beatIndex;
    logic               header;

    BeatStream cipherStream ();

    PathDirectionFsm PathDirectionFsm_i (
        .Clock     (Clock),
        .rstN      (rstN),
        .PathDone  (pathDone),
        .PipeEmpty (pipeEmpty),
        .Mode      (mode),
        .InputHold (inputHold)
    );

    BucketBeatCounter #(
        .BucketBeats (BucketBeats),
        .PathBuckets (PathBuckets)
    ) BucketBeatCounter_i (
        .Clock     (Clock),
        .rstN      (rstN),
        .InFire    (inFire),
        .BeatIndex (beatIndex),
        .Header    (header),
        .PathDone  (pathDone)
    );

    KeystreamPipe #(
        .CryptKey (CryptKey)
    ) KeystreamPipe_i (
        .Clock         (Clock),
        .rstN          (rstN),
        .Mode          (mode),
        .InputHold     (inputHold),
        .MemInData     (MemInData),
        .MemInValid    (MemInValid),
        .MemInReady    (MemInReady),
        .BackendWData  (BackendWData),
        .BackendWValid (BackendWValid),
        .BackendWReady (BackendWReady),
        .BeatIndex     (beatIndex),
        .Header        (header),
        .InFire        (inFire),
        .PipeEmpty     (pipeEmpty),
        .Out           (cipherStream.Source)
    );

    CipherMerge CipherMerge_i (
        .Clock         (Clock),
        .rstN          (rstN),
        .In            (cipherStream.Sink),
        .MemOutReady   (MemOutReady),
        .BackendRData  (BackendRData),
        .BackendRValid (BackendRValid),
        .MemOutData    (MemOutData),
        .MemOutValid   (MemOutValid)
    );

endmodule

`default_nettype wire

//--- sim/OramCrypt_assert.sv
// ----------------------------------------------------------
// Handshake and reset rules of the encryption layer, bound
// into the top level. Failures count up in assertFails.
// ----------------------------------------------------------
`default_nettype none

module OramCrypt_assert import OramCryptPkg::*; (
    input wire                 Clock,
    input wire                 rstN,
    input wire                 MemInReady,
    input wire                 BackendWReady,
    input wire                 BackendRValid,
    input wire                 MemOutValid,
    input wire                 MemOutReady,
    input wire [DataWidth-1:0] MemOutData
);
    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0;

    // Only one output side carries a beat in any cycle
    OneOutputSide: assert property (@(posedge Clock) disable iff (!rstN)
        !(MemOutValid && BackendRValid))
    else begin
        $error("Memory and backend outputs valid in the same cycle");
        assertFails++;
    end

    // Stalled memory beat must not change
    HeldMemBeat: assert property (@(posedge Clock) disable iff (!rstN)
        MemOutValid && !MemOutReady |=> MemOutValid && $stable(MemOutData))
    else begin
        $error("Memory output beat changed or dropped while stalled");
        assertFails++;
    end

    OneInputSide: assert property (@(posedge Clock) disable iff (!rstN)
        !(MemInReady && BackendWReady))
    else begin
        $error("Both input readies high together");
        assertFails++;
    end

    // Reset quiets readies and valids
    ResetQuiet: assert property (@(posedge Clock)
        !rstN |=> !MemInReady && !BackendWReady && !MemOutValid && !BackendRValid)
    else begin
        $error("Ready or valid high right after a reset edge");
        assertFails++;
    end

endmodule

bind OramCryptTop OramCrypt_assert OramCrypt_assert_i (
    .Clock         (Clock),
    .rstN          (rstN),
    .MemInReady    (MemInReady),
    .BackendWReady (BackendWReady),
    .BackendRValid (BackendRValid),
    .MemOutValid   (MemOutValid),
    .MemOutReady   (MemOutReady),
    .MemOutData    (MemOutData)
);

`default_nettype wire

//--- sim/OramCryptTb.sv
// ----------------------------------------------------------
// Testbench for the bucket encryption layer. Streams random
// paths in alternating direction and checks every output.
// ----------------------------------------------------------
`default_nettype none

module OramCryptTb import OramCryptPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BucketBeats = 4;
    localparam int PathBuckets = 3;
    localparam logic [DataWidth-1:0] CryptKey = 64'h0123456789ABCDEF;
    localparam logic [DataWidth-1:0] RoundStep = 64'h9E3779B97F4A7C15;
    localparam int PathBeats = BucketBeats * PathBuckets;
    localparam int NumPaths = 6;
    localparam int ClockPeriod = 4;
    localparam int TimeLimit = NumPaths * PathBeats * 40 * ClockPeriod;

    typedef struct packed {
        logic                 toMem;
        logic [7:0]           path;
        logic [DataWidth-1:0] data;
    } ExpBeat;

    logic                 Clock = 1'b0;
    logic                 rstN;
    logic [DataWidth-1:0] MemInData;
    logic                 MemInValid;
    logic                 MemInReady;
    logic [DataWidth-1:0] BackendWData;
    logic                 BackendWValid;
    logic                 BackendWReady;
    logic [DataWidth-1:0] BackendRData;
    logic                 BackendRValid;
    logic [DataWidth-1:0] MemOutData;
    logic                 MemOutValid;
    logic                 MemOutReady;

    logic [31:0] rngState = 32'd66295;
    ExpBeat      expQ [$];
    logic        curWrite = 1'b0;
    int          errorCount = 0;
    int          testErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          sentCount = 0;
    int          outCount = 0;
    int          pathOut = 0;

    always #(ClockPeriod / 2) Clock = ~Clock;

    OramCryptTop #(
        .BucketBeats (BucketBeats),
        .PathBuckets (PathBuckets),
        .CryptKey    (CryptKey)
    ) OramCryptTop_i (.*);

    // ----------------------------------------------------------
    // Random numbers and keystream model
    // ----------------------------------------------------------
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [DataWidth-1:0] keystreamWord(input logic [DataWidth-1:0] count);
        logic [DataWidth-1:0] s;
        int rot;
        s = count;
        for (int r = 0; r < 3; r++) begin
            rot = 13 + r;
            s = ((s << rot) | (s >> (DataWidth - rot))) ^ CryptKey;
            s = s + RoundStep * DataWidth'(r + 1);
        end
        return s;
    endfunction

    // ----------------------------------------------------------
    // Checking and reporting
    // ----------------------------------------------------------
    task automatic checkValue(input string name, input logic [DataWidth-1:0] expected,
                              input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        $display("Test %-12s done, %0d errors", name, testErrors);
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        testErrors = 0;
    endtask

    // Outputs are stable one ns before the rising edge
    always @(negedge Clock) begin
        ExpBeat e;
        string name;
        #1;
        if (BackendRValid === 1'b1 || (MemOutValid === 1'b1 && MemOutReady === 1'b1)) begin
            outCount++;
            if (expQ.size() == 0) begin
                $display("An output beat came out while no beat was pending");
                errorCount++;
                testErrors++;
            end else begin
                e = expQ.pop_front();
                name = $sformatf("path%0d", e.path);
                checkValue({name, "_dir"}, DataWidth'(e.toMem), DataWidth'(MemOutValid));
                checkValue({name, "_data"}, e.data, MemOutValid ? MemOutData : BackendRData);
                pathOut++;
                if (pathOut == PathBeats) begin
                    pathOut = 0;
                    finishTest(e.toMem ? {name, "_write"} : {name, "_read"});
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    task automatic driveCycle(input logic valid, input logic [DataWidth-1:0] data,
                              output logic fired);
        logic wrongReady;
        @(negedge Clock);
        MemOutReady = (nextRand() % 4) != 0;
        MemInValid = valid && !curWrite;
        BackendWValid = valid && curWrite;
        MemInData = data;
        BackendWData = data;
        #1;
        fired = curWrite ? (BackendWValid && BackendWReady) : (MemInValid && MemInReady);
        wrongReady = curWrite ? MemInReady : BackendWReady;
        if (wrongReady !== 1'b0) begin
            $display("Input ready rose on the side that is not the current direction");
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic sendPath(input int p);
        ExpBeat               e;
        logic [DataWidth-1:0] data;
        logic [IvWidth-1:0]   iv;
        logic                 fired;
        int                   k;
        int                   gap;
        for (int j = 0; j < PathBeats; j++) begin
            data = {nextRand(), nextRand()};
            k = j % BucketBeats;
            if (k == 0) begin
                iv = data[IvWidth-1:0];
            end
            e.toMem = curWrite;
            e.path = 8'(p);
            e.data = data ^ keystreamWord(DataWidth'(iv) + DataWidth'(k));
            // Header keeps its IV in the clear
            if (k == 0) begin
                e.data[IvWidth-1:0] = iv;
            end
            expQ.push_back(e);
            gap = nextRand() % 3;
            repeat (gap) driveCycle(1'b0, data, fired);
            fired = 1'b0;
            while (!fired) begin
                driveCycle(1'b1, data, fired);
            end
            sentCount++;
        end
        curWrite = !curWrite;
    endtask

    initial begin
        logic fired;
        rstN = 1'b0;
        MemInData = '0;
        MemInValid = 1'b0;
        BackendWData = '0;
        BackendWValid = 1'b0;
        MemOutReady = 1'b0;
        repeat (2) @(posedge Clock);
        #1;
        checkValue("reset_mem_in_ready", 0, DataWidth'(MemInReady));
        checkValue("reset_backend_w_ready", 0, DataWidth'(BackendWReady));
        checkValue("reset_backend_r_valid", 0, DataWidth'(BackendRValid));
        checkValue("reset_mem_out_valid", 0, DataWidth'(MemOutValid));
        @(negedge Clock);
        rstN = 1'b1;
        finishTest("reset");
        for (int p = 0; p < NumPaths; p++) begin
            sendPath(p);
        end
        while (expQ.size() != 0) begin
            driveCycle(1'b0, '0, fired);
        end
        // Extra cycles catch duplicated beats
        repeat (8) driveCycle(1'b0, '0, fired);
        checkValue("beat_count", DataWidth'(sentCount), DataWidth'(outCount));
        checkValue("assertions", 0, DataWidth'(OramCryptTop_i.OramCrypt_assert_i.assertFails));
        finishTest("beat_count");
        $display("Tests run %0d, tests failed %0d, errors %0d, beats %0d",
                 testsRun, testsFailed, errorCount, outCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TimeLimit);
        $display("Timeout, the run did not finish within %0d ns", TimeLimit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/OramCryptPkg.sv
hdl/BeatStream.sv
hdl/PathDirectionFsm.sv
hdl/BucketBeatCounter.sv
hdl/KeystreamPipe.sv
hdl/CipherMerge.sv
hdl/OramCryptTop.sv
sim/OramCrypt_assert.sv
sim/OramCryptTb.sv
